//--- src/cu_pkg.sv
package cu_pkg;

    typedef logic [7:0] instr_t;
    typedef logic [1:0] reg_idx_t;
    typedef logic [3:0] flags_t;
    typedef logic [3:0] alu_op_t;

    // Upper nibble of the instruction byte
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_MOV = 4'h1,
        OP_ADD = 4'h2,
        OP_SUB = 4'h3,
        OP_AND = 4'h4,
        OP_OR  = 4'h5,
        OP_JC  = 4'h9,
        OP_LDM = 4'hD,
        OP_STM = 4'hE
    } opcode_t;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    ccr_en;
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_r_en;
        logic mem_w_en;
    } mem_ctrl_t;

    typedef struct packed {
        logic     reg_w_en;
        logic     wb_from_mem;
        reg_idx_t dst;
    } wb_ctrl_t;

    // Youngest stage in the top byte
    typedef struct packed {
        instr_t id;
        instr_t ex;
        instr_t m;
        instr_t wb;
    } pipe_t;

    ////////////////////////////// Field helpers

    function automatic opcode_t op_of(input instr_t i);
        return opcode_t'(i[7:4]);
    endfunction

    function automatic reg_idx_t ra_of(input instr_t i);
        return i[3:2];
    endfunction

    function automatic reg_idx_t rb_of(input instr_t i);
        return i[1:0];
    endfunction

    function automatic logic is_alu(input instr_t i);
        return op_of(i) inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR};
    endfunction

    function automatic logic writes_reg(input instr_t i);
        return is_alu(i) || (op_of(i) == OP_LDM);
    endfunction

    // Loads land in rb, ALU results in ra
    function automatic reg_idx_t dst_of(input instr_t i);
        return (op_of(i) == OP_LDM) ? rb_of(i) : ra_of(i);
    endfunction

endpackage

//--- src/stage_regs.sv
`timescale 1ns/100ps

module stage_regs (
    input  logic           CLK,
    input  logic           RESET,
    input  cu_pkg::instr_t instr,
    input  logic           stall,
    input  logic           flush,
    output cu_pkg::pipe_t  pipe,
    output logic           rst_flush
);

    cu_pkg::instr_t id_next;
    cu_pkg::instr_t ex_next;
    logic           kill;

    assign kill = flush || rst_flush;

    // Fetched byte is dropped on a squash
    always_comb begin
        if (kill) begin
            id_next = '0;
        end else if (stall) begin
            id_next = pipe.id;
        end else begin
            id_next = instr;
        end
    end

    // Bubble into execute on stall or squash
    always_comb begin
        if (kill || stall) begin
            ex_next = '0;
        end else begin
            ex_next = pipe.id;
        end
    end

    //////////////////////////////
    // Stage registers
    //////////////////////////////

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            pipe      <= '0;
            rst_flush <= 1'b1;
        end else begin
            pipe.id   <= id_next;
            pipe.ex   <= ex_next;
            pipe.m    <= pipe.ex;
            pipe.wb   <= pipe.m;
            rst_flush <= 1'b0;
        end
    end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  cu_pkg::pipe_t    pipe,
    input  cu_pkg::flags_t   ccr,
    input  logic             rst_flush,
    output logic             stall,
    output logic             flush,
    output logic             pc_en,
    output logic             pc_redirect,
    output cu_pkg::fwd_sel_t fwd_a,
    output cu_pkg::fwd_sel_t fwd_b
);

    function automatic logic reads_ra(input cu_pkg::instr_t i);
        return cu_pkg::op_of(i) inside {
            cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND, cu_pkg::OP_OR,
            cu_pkg::OP_LDM, cu_pkg::OP_STM
        };
    endfunction

    // JC takes its target from rb
    function automatic logic reads_rb(input cu_pkg::instr_t i);
        return cu_pkg::op_of(i) inside {
            cu_pkg::OP_MOV, cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND,
            cu_pkg::OP_OR, cu_pkg::OP_JC, cu_pkg::OP_STM
        };
    endfunction

    // Newest producer wins. A load in memory has no data yet
    function automatic cu_pkg::fwd_sel_t pick_src(
        input logic             rd,
        input cu_pkg::reg_idx_t idx,
        input cu_pkg::instr_t   m,
        input cu_pkg::instr_t   wb
    );
        if (rd && cu_pkg::is_alu(m) && (cu_pkg::dst_of(m) == idx)) begin
            return cu_pkg::FWD_MEM;
        end
        if (rd && cu_pkg::writes_reg(wb) && (cu_pkg::dst_of(wb) == idx)) begin
            return cu_pkg::FWD_WB;
        end
        return cu_pkg::FWD_RF;
    endfunction

    cu_pkg::reg_idx_t id_ra;
    cu_pkg::reg_idx_t id_rb;
    cu_pkg::reg_idx_t ex_ra;
    cu_pkg::reg_idx_t ex_rb;
    logic             load_use;
    logic             taken;

    assign id_ra = cu_pkg::ra_of(pipe.id);
    assign id_rb = cu_pkg::rb_of(pipe.id);
    assign ex_ra = cu_pkg::ra_of(pipe.ex);
    assign ex_rb = cu_pkg::rb_of(pipe.ex);

    //////////////////////////////
    // Load-use and branch
    //////////////////////////////

    assign load_use = (cu_pkg::op_of(pipe.ex) == cu_pkg::OP_LDM) &&
                      ((reads_ra(pipe.id) && (id_ra == ex_rb)) ||
                       (reads_rb(pipe.id) && (id_rb == ex_rb)));

    // ra picks the flag bit
    assign taken = (cu_pkg::op_of(pipe.ex) == cu_pkg::OP_JC) && ccr[ex_ra];

    // Stage bytes are not trusted until the reset flush is over
    assign stall       = load_use && !rst_flush;
    assign flush       = taken && !rst_flush;
    assign pc_en       = !stall;
    assign pc_redirect = flush;

    //////////////////////////////
    // Operand forwarding
    //////////////////////////////

    assign fwd_a = pick_src(reads_ra(pipe.ex), ex_ra, pipe.m, pipe.wb);
    assign fwd_b = pick_src(reads_rb(pipe.ex), ex_rb, pipe.m, pipe.wb);

endmodule

//--- src/stage_decode.sv
`timescale 1ns/100ps

module stage_decode (
    input  cu_pkg::pipe_t     pipe,
    output cu_pkg::ex_ctrl_t  ex_ctrl,
    output cu_pkg::mem_ctrl_t mem_ctrl,
    output cu_pkg::wb_ctrl_t  wb_ctrl
);

    cu_pkg::opcode_t ex_op;
    cu_pkg::opcode_t m_op;
    cu_pkg::opcode_t wb_op;

    assign ex_op = cu_pkg::op_of(pipe.ex);
    assign m_op  = cu_pkg::op_of(pipe.m);
    assign wb_op = cu_pkg::op_of(pipe.wb);

    //////////////////////////////
    // Execute
    //////////////////////////////

    // MOV passes through the ALU but leaves the flags alone
    always_comb begin
        ex_ctrl = '0;
        case (ex_op)
            cu_pkg::OP_MOV: begin
                ex_ctrl.alu_op = cu_pkg::alu_op_t'(ex_op);
            end
            cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND, cu_pkg::OP_OR: begin
                ex_ctrl.alu_op = cu_pkg::alu_op_t'(ex_op);
                ex_ctrl.ccr_en = 1'b1;
            end
            default: begin
                ex_ctrl = '0;
            end
        endcase
    end

    //////////////////////////////
    // Memory
    //////////////////////////////

    always_comb begin
        mem_ctrl = '0;
        case (m_op)
            cu_pkg::OP_LDM: begin
                mem_ctrl.mem_r_en = 1'b1;
            end
            cu_pkg::OP_STM: begin
                mem_ctrl.mem_w_en = 1'b1;
            end
            default: begin
                mem_ctrl = '0;
            end
        endcase
    end

    //////////////////////////////
    // Write-back
    //////////////////////////////

    // Load data comes from memory, the rest from the ALU result
    always_comb begin
        wb_ctrl = '0;
        if (cu_pkg::writes_reg(pipe.wb)) begin
            wb_ctrl.reg_w_en    = 1'b1;
            wb_ctrl.wb_from_mem = (wb_op == cu_pkg::OP_LDM);
            wb_ctrl.dst         = cu_pkg::dst_of(pipe.wb);
        end
    end

endmodule

//--- src/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  logic              CLK,
    input  logic              RESET,
    input  cu_pkg::instr_t    instr,
    input  cu_pkg::flags_t    ccr,
    output logic              pc_en,
    output logic              pc_redirect,
    output cu_pkg::ex_ctrl_t  ex_ctrl,
    output cu_pkg::fwd_sel_t  fwd_a,
    output cu_pkg::fwd_sel_t  fwd_b,
    output cu_pkg::mem_ctrl_t mem_ctrl,
    output cu_pkg::wb_ctrl_t  wb_ctrl
);

    cu_pkg::pipe_t pipe;
    logic          rst_flush;
    logic          stall;
    logic          flush;

    stage_regs stage_regs_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .instr     (instr),
        .stall     (stall),
        .flush     (flush),
        .pipe      (pipe),
        .rst_flush (rst_flush)
    );

    hazard_unit hazard_unit_inst (
        .pipe        (pipe),
        .ccr         (ccr),
        .rst_flush   (rst_flush),
        .stall       (stall),
        .flush       (flush),
        .pc_en       (pc_en),
        .pc_redirect (pc_redirect),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

    stage_decode stage_decode_inst (
        .pipe     (pipe),
        .ex_ctrl  (ex_ctrl),
        .mem_ctrl (mem_ctrl),
        .wb_ctrl  (wb_ctrl)
    );

endmodule

//--- tests/control_unit_chk.sv
`timescale 1ns/100ps

module control_unit_chk (
    input logic              CLK,
    input logic              RESET,
    input cu_pkg::instr_t    instr,
    input cu_pkg::flags_t    ccr,
    input logic              pc_en,
    input logic              pc_redirect,
    input cu_pkg::ex_ctrl_t  ex_ctrl,
    input cu_pkg::fwd_sel_t  fwd_a,
    input cu_pkg::fwd_sel_t  fwd_b,
    input cu_pkg::mem_ctrl_t mem_ctrl,
    input cu_pkg::wb_ctrl_t  wb_ctrl
);

    // MOV to OR go through the ALU
    function automatic logic alu_class(input cu_pkg::instr_t b);
        return (b[7:4] >= 4'h1) && (b[7:4] <= 4'h5);
    endfunction

    function automatic logic needs_ra(input cu_pkg::instr_t b);
        return ((b[7:4] >= 4'h2) && (b[7:4] <= 4'h5)) ||
               (b[7:4] == cu_pkg::OP_LDM) || (b[7:4] == cu_pkg::OP_STM);
    endfunction

    // JC reads its target from rb
    function automatic logic needs_rb(input cu_pkg::instr_t b);
        return alu_class(b) || (b[7:4] == cu_pkg::OP_JC) || (b[7:4] == cu_pkg::OP_STM);
    endfunction

    function automatic logic has_dest(input cu_pkg::instr_t b);
        return alu_class(b) || (b[7:4] == cu_pkg::OP_LDM);
    endfunction

    function automatic cu_pkg::reg_idx_t dest_reg(input cu_pkg::instr_t b);
        return (b[7:4] == cu_pkg::OP_LDM) ? b[1:0] : b[3:2];
    endfunction

    function automatic cu_pkg::fwd_sel_t operand_src(
        input logic             rd,
        input cu_pkg::reg_idx_t idx,
        input cu_pkg::instr_t   m,
        input cu_pkg::instr_t   wb
    );
        if (rd && alu_class(m) && (dest_reg(m) == idx)) begin
            return cu_pkg::FWD_MEM;
        end
        if (rd && has_dest(wb) && (dest_reg(wb) == idx)) begin
            return cu_pkg::FWD_WB;
        end
        return cu_pkg::FWD_RF;
    endfunction

    cu_pkg::instr_t    s_id;
    cu_pkg::instr_t    s_ex;
    cu_pkg::instr_t    s_m;
    cu_pkg::instr_t    s_wb;
    logic              s_first;
    logic [3:0]        redir_d;
    cu_pkg::ex_ctrl_t  exp_ex;
    cu_pkg::mem_ctrl_t exp_mem;
    cu_pkg::wb_ctrl_t  exp_wb;
    cu_pkg::fwd_sel_t  exp_fwd_a;
    cu_pkg::fwd_sel_t  exp_fwd_b;
    logic              exp_stall;
    logic              exp_taken;
    int                fail_count = 0;

    ////////////////////////////// Shadow pipeline

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            s_id    <= '0;
            s_ex    <= '0;
            s_m     <= '0;
            s_wb    <= '0;
            s_first <= 1'b1;
            redir_d <= '0;
        end else begin
            if (s_first || pc_redirect) begin
                s_id <= '0;
            end else if (pc_en) begin
                s_id <= instr;
            end
            if (s_first || pc_redirect || !pc_en) begin
                s_ex <= '0;
            end else begin
                s_ex <= s_id;
            end
            s_m     <= s_ex;
            s_wb    <= s_m;
            s_first <= 1'b0;
            redir_d <= {redir_d[2:0], pc_redirect};
        end
    end

    always_comb begin
        exp_ex.alu_op    = alu_class(s_ex) ? s_ex[7:4] : 4'h0;
        exp_ex.ccr_en    = alu_class(s_ex) && (s_ex[7:4] != cu_pkg::OP_MOV);
        exp_mem.mem_r_en = (s_m[7:4] == cu_pkg::OP_LDM);
        exp_mem.mem_w_en = (s_m[7:4] == cu_pkg::OP_STM);
        exp_wb           = '0;
        if (has_dest(s_wb)) begin
            exp_wb.reg_w_en    = 1'b1;
            exp_wb.wb_from_mem = (s_wb[7:4] == cu_pkg::OP_LDM);
            exp_wb.dst         = dest_reg(s_wb);
        end
        exp_fwd_a = operand_src(needs_ra(s_ex), s_ex[3:2], s_m, s_wb);
        exp_fwd_b = operand_src(needs_rb(s_ex), s_ex[1:0], s_m, s_wb);
        exp_stall = (s_ex[7:4] == cu_pkg::OP_LDM) &&
                    ((needs_ra(s_id) && (s_id[3:2] == s_ex[1:0])) ||
                     (needs_rb(s_id) && (s_id[1:0] == s_ex[1:0])));
        exp_taken = (s_ex[7:4] == cu_pkg::OP_JC) && ccr[s_ex[3:2]];
    end

    ////////////////////////////// Assertions

    a_reset_idle: assert property (@(posedge CLK) disable iff (RESET)
        s_first |-> (pc_en && !pc_redirect && (mem_ctrl == '0) && !wb_ctrl.reg_w_en))
    else begin
        fail_count = fail_count + 1;
        $error("Control outputs were active in the first cycle after reset");
    end

    a_ex_ctrl: assert property (@(posedge CLK) disable iff (RESET) ex_ctrl == exp_ex)
    else begin
        fail_count = fail_count + 1;
        $error("error at %0t: ex_ctrl got %h expected %h",
               $time, $sampled(ex_ctrl), $sampled(exp_ex));
    end

    a_fwd: assert property (@(posedge CLK) disable iff (RESET)
        (fwd_a == exp_fwd_a) && (fwd_b == exp_fwd_b))
    else begin
        fail_count = fail_count + 1;
        $error("error at %0t: fwd_a/fwd_b got %0d/%0d expected %0d/%0d", $time,
               $sampled(fwd_a), $sampled(fwd_b), $sampled(exp_fwd_a), $sampled(exp_fwd_b));
    end

    a_pc_en: assert property (@(posedge CLK) disable iff (RESET) pc_en == !exp_stall)
    else begin
        fail_count = fail_count + 1;
        $error("error at %0t: pc_en got %b expected %b",
               $time, $sampled(pc_en), !$sampled(exp_stall));
    end

    // A load-use stall is one cycle with a bubble behind it
    a_stall_once: assert property (@(posedge CLK) disable iff (RESET)
        !pc_en |=> (pc_en && (ex_ctrl == '0)))
    else begin
        fail_count = fail_count + 1;
        $error("Stall lasted more than one cycle or execute did not get a bubble");
    end

    a_redirect: assert property (@(posedge CLK) disable iff (RESET) pc_redirect == exp_taken)
    else begin
        fail_count = fail_count + 1;
        $error("error at %0t: pc_redirect got %b expected %b",
               $time, $sampled(pc_redirect), $sampled(exp_taken));
    end

    a_squash: assert property (@(posedge CLK) disable iff (RESET)
        !((redir_d[1] || redir_d[2]) && (mem_ctrl != '0)) &&
        !((redir_d[2] || redir_d[3]) && wb_ctrl.reg_w_en))
    else begin
        fail_count = fail_count + 1;
        $error("A byte squashed by a taken JC reached memory or write-back");
    end

    a_mem_ctrl: assert property (@(posedge CLK) disable iff (RESET) mem_ctrl == exp_mem)
    else begin
        fail_count = fail_count + 1;
        $error("error at %0t: mem_ctrl got %b expected %b",
               $time, $sampled(mem_ctrl), $sampled(exp_mem));
    end

    a_wb_ctrl: assert property (@(posedge CLK) disable iff (RESET) wb_ctrl == exp_wb)
    else begin
        fail_count = fail_count + 1;
        $error("error at %0t: wb_ctrl got %h expected %h",
               $time, $sampled(wb_ctrl), $sampled(exp_wb));
    end

endmodule

//--- tests/control_unit_tb.sv
`timescale 1ns/100ps

module control_unit_tb;

    localparam int RANDOM_CYCLES   = 2000;
    localparam int DIRECTED_CYCLES = 40;
    localparam int WATCHDOG_NS     = (RANDOM_CYCLES + DIRECTED_CYCLES + 20) * 10 * 2;

    logic              CLK;
    logic              RESET;
    cu_pkg::instr_t    instr;
    cu_pkg::flags_t    ccr;
    logic              pc_en;
    logic              pc_redirect;
    cu_pkg::ex_ctrl_t  ex_ctrl;
    cu_pkg::fwd_sel_t  fwd_a;
    cu_pkg::fwd_sel_t  fwd_b;
    cu_pkg::mem_ctrl_t mem_ctrl;
    cu_pkg::wb_ctrl_t  wb_ctrl;
    int                cycles;
    cu_pkg::opcode_t   kept_ops [9] = '{
        cu_pkg::OP_NOP, cu_pkg::OP_MOV, cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND,
        cu_pkg::OP_OR, cu_pkg::OP_JC, cu_pkg::OP_LDM, cu_pkg::OP_STM
    };

    control_unit control_unit_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr       (instr),
        .ccr         (ccr),
        .pc_en       (pc_en),
        .pc_redirect (pc_redirect),
        .ex_ctrl     (ex_ctrl),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_ctrl    (mem_ctrl),
        .wb_ctrl     (wb_ctrl)
    );

    bind control_unit control_unit_chk control_unit_chk_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr       (instr),
        .ccr         (ccr),
        .pc_en       (pc_en),
        .pc_redirect (pc_redirect),
        .ex_ctrl     (ex_ctrl),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_ctrl    (mem_ctrl),
        .wb_ctrl     (wb_ctrl)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    // Twice the stimulus length
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("Verification failed");
        $finish;
    end

    task automatic drive_byte(input cu_pkg::instr_t b, input cu_pkg::flags_t f);
        @(posedge CLK);
        instr  <= b;
        ccr    <= f;
        cycles = cycles + 1;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        int          idx;
        r   = $urandom;
        idx = int'(r[31:8] % 24'd9);
        drive_byte({kept_ops[idx], r[3:0]}, r[7:4]);
    endtask

    ////////////////////////////// Directed sequences

    task automatic load_use_seq();
        // LDM into r2, then ADD reading r2 as ra
        drive_byte(8'hD6, 4'h0);
        drive_byte(8'h2B, 4'h0);
        drive_byte(8'hE6, 4'h0);
        repeat (3) drive_byte(8'h00, 4'h0);
        // LDM into r1, then MOV r0 from r1
        drive_byte(8'hD1, 4'h0);
        drive_byte(8'h11, 4'h0);
        repeat (4) drive_byte(8'h00, 4'h0);
    endtask

    // JC on flag 2 with an ADD and an STM right behind it
    task automatic branch_seq(input cu_pkg::flags_t f);
        drive_byte(8'h99, f);
        drive_byte(8'h25, f);
        drive_byte(8'hE5, f);
        repeat (4) drive_byte(8'h00, f);
    endtask

    initial begin
        int fails;
        void'($urandom(86886));
        RESET  = 1'b1;
        // ADD r1 sits on the bus through the reset flush cycle
        instr  = 8'h25;
        ccr    = '0;
        cycles = 0;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        load_use_seq();
        branch_seq(4'b0100);
        branch_seq(4'b1011);
        repeat (RANDOM_CYCLES) drive_random();
        repeat (6) drive_byte(8'h00, 4'h0);
        @(posedge CLK);
        fails = control_unit_inst.control_unit_chk_inst.fail_count;
        $display("Run ended after %0d cycles with %0d assertion failures", cycles, fails);
        if (fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- all.f
src/cu_pkg.sv
src/stage_regs.sv
src/hazard_unit.sv
src/stage_decode.sv
src/control_unit.sv
tests/control_unit_chk.sv
tests/control_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module control_unit_tb -f all.f
./obj_dir/Vcontrol_unit_tb +verilator+error+limit+100000 | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "Simulation PASSED"
    exit 0
fi
echo "Simulation FAILED"
exit 1
